//--- Bender.yml
package:
  name: exec_core

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/exec_if.sv
      - rtl/instr_decoder.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/flag_unit.sv
      - rtl/exec_core.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/exec_core_chk.sv
      - tests/exec_core_tb.sv

//--- exec_core.f
rtl/exec_pkg.sv
rtl/exec_if.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/flag_unit.sv
rtl/exec_core.sv
tests/clk_gen.sv
tests/exec_core_chk.sv
tests/exec_core_tb.sv

//--- rtl/alu.sv
module alu (
	exec_if.sink             dec,
	input  logic [31:0]      data_a,
	input  logic [31:0]      data_b,
	output logic [31:0]      alu_result,
	output exec_pkg::flag_e  next_flag,
	output logic             flag_update
);
	import exec_pkg::*;

	logic [31:0] op_b;
	logic [32:0] sum;
	logic [32:0] diff;
	logic [63:0] product;
	logic [31:0] quotient;

	// Flag from bits 32 and 31 of a 33-bit sum or difference
	function automatic flag_e carry_flag(input logic [1:0] top);
		case (top)
			2'b00:   return FLAG_NOT_ACTIVED;
			2'b10:   return FLAG_UNDERFLOW;
			default: return FLAG_OVERFLOW;
		endcase
	endfunction

	assign op_b = dec.use_imm ? dec.imm : data_b;

	assign sum      = {1'b0, data_a} + {1'b0, op_b};
	assign diff     = {1'b0, data_a} - {1'b0, op_b};
	assign product  = data_a * op_b;
	assign quotient = (op_b == '0) ? '0 : data_a / op_b; // Guard divide by zero

	always_comb begin
		alu_result  = '0;
		next_flag   = FLAG_NOT_ACTIVED;
		flag_update = 1'b1;
		case (dec.op)
			ADDI: begin
				alu_result = sum[31:0];
				next_flag  = carry_flag(sum[32:31]);
			end
			SUBI: begin
				alu_result = diff[31:0];
				next_flag  = carry_flag(diff[32:31]);
			end
			TYPE_R: begin
				case (dec.func)
					ADD: begin
						alu_result = sum[31:0];
						next_flag  = carry_flag(sum[32:31]);
					end
					SUB: begin
						alu_result = diff[31:0];
						next_flag  = carry_flag(diff[32:31]);
					end
					MUL: begin
						alu_result = product[31:0];
						if (product[63:32] != '0)
							next_flag = FLAG_OVERFLOW;
					end
					DIV: begin
						alu_result = quotient;
						if (op_b == '0)
							next_flag = FLAG_EXCEPTION;
					end
					AND: alu_result = data_a & op_b;
					OR:  alu_result = data_a | op_b;
					NOT: alu_result = ~op_b;
					default: begin
						flag_update = 1'b0; // Unknown function
					end
				endcase
			end
			ANDI: alu_result = data_a & op_b;
			ORI:  alu_result = data_a | op_b;
			CMP: begin
				// Unsigned compare, below leaves NOT_ACTIVED
				if (data_a == op_b)
					next_flag = FLAG_EQUAL;
				else if (data_a > op_b)
					next_flag = FLAG_ABOVE;
			end
			BRFL: begin
				alu_result  = data_a;
				flag_update = 1'b0; // Flag only tested
			end
			default: begin
				flag_update = 1'b0;
			end
		endcase
	end

endmodule

//--- rtl/exec_core.sv
module exec_core #(
	parameter int NUM_REGS = 32
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	output logic        result_valid,
	output logic [31:0] result,
	output logic [2:0]  flag,
	output logic        branch
);
	import exec_pkg::*;

	logic [REG_ADDR_W-1:0] rs_addr;
	logic [REG_ADDR_W-1:0] rt_addr;
	logic [31:0]           rs_data;
	logic [31:0]           rt_data;
	logic [31:0]           alu_result;
	flag_e                 next_flag;
	logic                  flag_update;

	exec_if dec_if ();

	instr_decoder #(
		.NUM_REGS (NUM_REGS)
	) u_decoder (
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.dec         (dec_if.source)
	);

	// Written on the same edge as the output registers
	reg_file #(
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk     (clk),
		.reset   (reset),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.wr_en   (dec_if.wr_en),
		.wr_addr (dec_if.rd),
		.wr_data (alu_result),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	alu u_alu (
		.dec         (dec_if.sink),
		.data_a      (rs_data),
		.data_b      (rt_data),
		.alu_result  (alu_result),
		.next_flag   (next_flag),
		.flag_update (flag_update)
	);

	flag_unit u_flag_unit (
		.clk          (clk),
		.reset        (reset),
		.dec          (dec_if.sink),
		.alu_result   (alu_result),
		.next_flag    (next_flag),
		.flag_update  (flag_update),
		.result_valid (result_valid),
		.result       (result),
		.flag         (flag),
		.branch       (branch)
	);

endmodule

//--- rtl/exec_if.sv
interface exec_if;
	import exec_pkg::*;

	logic                  valid;
	op_e                   op;
	func_e                 func;
	logic                  use_imm; // Immediate replaces rt operand
	logic [31:0]           imm;
	logic [REG_ADDR_W-1:0] rd;
	logic                  wr_en;

	modport source (
		output valid, op, func, use_imm, imm, rd, wr_en
	);

	modport sink (
		input valid, op, func, use_imm, imm, rd, wr_en
	);

endinterface

//--- rtl/exec_pkg.sv
package exec_pkg;

	localparam int REG_ADDR_W = 5;

	// Opcodes in bits 31:29
	typedef enum logic [2:0] {
		ADDI   = 3'b000,
		SUBI   = 3'b001,
		TYPE_R = 3'b010,
		ANDI   = 3'b011,
		ORI    = 3'b100,
		BRFL   = 3'b101,
		CMP    = 3'b110
	} op_e;

	// R-type function field
	typedef enum logic [5:0] {
		ADD = 6'b100000,
		SUB = 6'b100010,
		MUL = 6'b000010,
		DIV = 6'b000001,
		AND = 6'b100100,
		OR  = 6'b100101,
		NOT = 6'b100111
	} func_e;

	typedef enum logic [2:0] {
		FLAG_NOT_ACTIVED = 3'd0,
		FLAG_EQUAL       = 3'd1,
		FLAG_EXCEPTION   = 3'd2,
		FLAG_OVERFLOW    = 3'd3,
		FLAG_UNDERFLOW   = 3'd4,
		FLAG_ABOVE       = 3'd5
	} flag_e;

	typedef struct packed {
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [7:0]            unused;
		func_e                 func;
	} instr_r_t;

	typedef struct packed {
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [2:0]            unused;
		logic [15:0]           imm;
	} instr_i_t;

	// Same word, register or immediate layout
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

//--- rtl/flag_unit.sv
module flag_unit (
	input  logic             clk,
	input  logic             reset,
	exec_if.sink             dec,
	input  logic [31:0]      alu_result,
	input  exec_pkg::flag_e  next_flag,
	input  logic             flag_update,
	output logic             result_valid,
	output logic [31:0]      result,
	output exec_pkg::flag_e  flag,
	output logic             branch
);
	import exec_pkg::*;

	logic take_branch;

	// Compare against the flag stored before this instruction
	assign take_branch = (dec.op == BRFL) && (3'(flag) != dec.imm[2:0]);

	always_ff @(posedge clk) begin
		if (!reset) begin
			result_valid <= 1'b0;
			flag         <= FLAG_NOT_ACTIVED;
			branch       <= 1'b0;
		end else begin
			result_valid <= dec.valid;
			branch       <= dec.valid && take_branch;
			if (dec.valid && flag_update)
				flag <= next_flag;
		end
	end

	always_ff @(posedge clk) begin
		if (dec.valid)
			result <= alu_result;
	end

endmodule

//--- rtl/instr_decoder.sv
module instr_decoder #(
	parameter int NUM_REGS = 32
) (
	input  logic                            instr_valid,
	input  exec_pkg::instr_u                instr,
	output logic [exec_pkg::REG_ADDR_W-1:0] rs_addr,
	output logic [exec_pkg::REG_ADDR_W-1:0] rt_addr,
	exec_if.source                          dec
);
	import exec_pkg::*;

	// Smaller register files ignore the upper address bits
	localparam logic [REG_ADDR_W-1:0] ADDR_MASK = REG_ADDR_W'(NUM_REGS - 1);

	op_e  op;
	logic is_r;

	assign op   = instr.r.op;
	assign is_r = (op == TYPE_R) || (op == CMP); // Both register operands

	assign rs_addr = instr.r.rs & ADDR_MASK;
	assign rt_addr = is_r ? (instr.r.rt & ADDR_MASK) : '0;

	assign dec.valid = instr_valid;
	assign dec.op    = op;
	assign dec.func  = (op == TYPE_R) ? instr.r.func : ADD;
	assign dec.imm   = is_r ? '0 : {16'b0, instr.i.imm};
	assign dec.rd    = instr.i.rd & ADDR_MASK;

	always_comb begin
		dec.use_imm = 1'b0;
		dec.wr_en   = 1'b0;
		case (op)
			ADDI, SUBI, ANDI, ORI: begin
				dec.use_imm = 1'b1;
				dec.wr_en   = instr_valid;
			end
			TYPE_R: begin
				dec.wr_en = instr_valid;
			end
			BRFL: begin
				dec.use_imm = 1'b1; // Flag code rides in imm
			end
			default: begin
				// CMP and unused opcode write nothing
				dec.wr_en = 1'b0;
			end
		endcase
	end

endmodule

//--- rtl/reg_file.sv
module reg_file #(
	parameter int NUM_REGS = 32
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rs_addr,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rt_addr,
	input  logic                            wr_en,
	input  logic [exec_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [31:0]                     wr_data,
	output logic [31:0]                     rs_data,
	output logic [31:0]                     rt_data
);

	localparam int ADDR_W = $clog2(NUM_REGS);

	logic [31:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr[ADDR_W-1:0] != '0)) begin
			regs[wr_addr[ADDR_W-1:0]] <= wr_data; // r0 stays zero
		end
	end

	assign rs_data = regs[rs_addr[ADDR_W-1:0]];
	assign rt_data = regs[rt_addr[ADDR_W-1:0]];

endmodule

//--- tests/clk_gen.sv
module clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b1;
	end

	always #2 clk = ~clk; // Period 4

endmodule

//--- tests/exec_core_chk.sv
module exec_core_chk (
	input logic       clk,
	input logic       reset,
	input logic       instr_valid,
	input logic       result_valid,
	input logic [2:0] flag,
	input logic       branch
);

	int fail_count = 0;

	reset_clears_valid: assert property (@(posedge clk) !reset |=> !result_valid)
		else begin
			fail_count++;
			$error("result_valid high after a reset cycle");
		end

	// One cycle from strobe to result
	valid_follows_strobe: assert property (@(posedge clk) disable iff (!reset)
		$past(reset) |-> (result_valid == $past(instr_valid)))
		else begin
			fail_count++;
			$error("result_valid did not follow instr_valid by one cycle");
		end

	branch_needs_valid: assert property (@(posedge clk) disable iff (!reset)
		branch |-> result_valid)
		else begin
			fail_count++;
			$error("branch high without result_valid");
		end

	flag_defined: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown(flag) && (flag <= 3'd5))
		else begin
			fail_count++;
			$error("flag holds an undefined code");
		end

endmodule

bind exec_core exec_core_chk chk0 (
	.clk          (clk),
	.reset        (reset),
	.instr_valid  (instr_valid),
	.result_valid (result_valid),
	.flag         (flag),
	.branch       (branch)
);

//--- tests/exec_core_tb.sv
module exec_core_tb;
	import exec_pkg::*;

	localparam int NUM_REGS = 32;
	localparam int MAX_CYCLES = 400; // About 150 issue cycles plus reset, with margin

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic        result_valid;
	logic [31:0] result;
	logic [2:0]  flag;
	logic        branch;

	int seed = 51244;
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int total;

	logic [31:0] shadow_regs [NUM_REGS];
	logic [2:0]  shadow_flag;

	// Expected outputs of the instruction in flight
	logic        pend_valid;
	logic [31:0] pend_result;
	logic        pend_branch;

	clk_gen clk0 (.clk (clk), .reset (reset));

	exec_core #(
		.NUM_REGS (NUM_REGS)
	) dut0 (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.result_valid (result_valid),
		.result       (result),
		.flag         (flag),
		.branch       (branch)
	);

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] word_r(input logic [2:0] op, input logic [5:0] fn,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		return {op, rd, rs, rt, 8'h00, fn};
	endfunction

	function automatic logic [31:0] word_i(input logic [2:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rd, rs, 3'b000, imm};
	endfunction

	function automatic logic [2:0] top_bits_flag(input logic [32:0] wide);
		if (wide[32:31] == 2'b00)
			return FLAG_NOT_ACTIVED;
		if (wide[32:31] == 2'b10)
			return FLAG_UNDERFLOW;
		return FLAG_OVERFLOW;
	endfunction

	// Reference model, updates the shadow state in issue order
	task automatic predict(input logic [31:0] word);
		logic [2:0]  op;
		logic [5:0]  fn;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [32:0] wide;
		logic [63:0] prod;
		logic [2:0]  fl;
		logic        wr;
		logic        upd;
		op  = word[31:29];
		fn  = word[5:0];
		a   = shadow_regs[word[23:19]];
		b   = (op == TYPE_R || op == CMP) ? shadow_regs[word[18:14]] : {16'h0, word[15:0]};
		res = '0;
		fl  = FLAG_NOT_ACTIVED;
		wr  = 1'b1;
		upd = 1'b1;
		pend_branch = 1'b0;
		if (op == ADDI || (op == TYPE_R && fn == ADD)) begin
			wide = {1'b0, a} + {1'b0, b};
			res  = wide[31:0];
			fl   = top_bits_flag(wide);
		end else if (op == SUBI || (op == TYPE_R && fn == SUB)) begin
			wide = {1'b0, a} - {1'b0, b};
			res  = wide[31:0];
			fl   = top_bits_flag(wide);
		end else if (op == TYPE_R && fn == MUL) begin
			prod = 64'(a) * 64'(b);
			res  = prod[31:0];
			fl   = (prod[63:32] != 0) ? FLAG_OVERFLOW : FLAG_NOT_ACTIVED;
		end else if (op == TYPE_R && fn == DIV) begin
			res = (b == 0) ? 32'h0 : a / b;
			fl  = (b == 0) ? FLAG_EXCEPTION : FLAG_NOT_ACTIVED;
		end else if ((op == TYPE_R && fn == AND) || op == ANDI) begin
			res = a & b;
		end else if ((op == TYPE_R && fn == OR) || op == ORI) begin
			res = a | b;
		end else if (op == TYPE_R && fn == NOT) begin
			res = ~b; // Inverts the rt operand
		end else if (op == CMP) begin
			wr = 1'b0;
			fl = (a == b) ? FLAG_EQUAL : ((a > b) ? FLAG_ABOVE : FLAG_NOT_ACTIVED);
		end else if (op == BRFL) begin
			wr  = 1'b0;
			upd = 1'b0;
			res = a;
			pend_branch = (shadow_flag != word[2:0]);
		end
		if (wr && word[28:24] != 0)
			shadow_regs[word[28:24]] = res;
		if (upd)
			shadow_flag = fl;
		pend_result = res;
		pend_valid  = 1'b1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_outputs();
		assert (result_valid === pend_valid) else begin
			other_errors++;
			$display("result_valid did not match the issued instruction at %0t", $time);
		end
		if (pend_valid) begin
			check_value("result", result, pend_result);
		end
		check_value("flag", 32'(flag), 32'(shadow_flag)); // Holds across idle cycles
		check_value("branch", 32'(branch), 32'(pend_valid && pend_branch));
	endtask

	// Drive one cycle, check the instruction issued on the cycle before
	task automatic step(input logic valid, input logic [31:0] word);
		@(posedge clk);
		instr_valid <= valid;
		instr       <= word;
		@(negedge clk);
		check_outputs();
		pend_valid = 1'b0;
		if (valid)
			predict(word);
	endtask

	// Needs r31 = 0x10000
	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		step(1'b1, word_i(ADDI, rd, 5'd0, value[31:16]));
		step(1'b1, word_r(TYPE_R, MUL, rd, rd, 5'd31));
		step(1'b1, word_i(ORI, rd, rd, value[15:0]));
	endtask

	task automatic test_load_logic();
		step(1'b1, word_i(ADDI, 5'd31, 5'd0, 16'hFFFF));
		step(1'b1, word_i(ADDI, 5'd31, 5'd31, 16'h0001));
		step(1'b1, word_i(ADDI, 5'd1, 5'd0, 16'h1234));
		step(1'b1, word_i(ORI, 5'd2, 5'd0, 16'hF0F0));
		step(1'b1, word_i(ADDI, 5'd3, 5'd0, 16'(rand32())));
		step(1'b1, word_i(ORI, 5'd4, 5'd0, 16'(rand32())));
		for (int r = 1; r <= 4; r++)
			step(1'b1, word_i(BRFL, 5'd0, 5'(r), 16'h0000));
		step(1'b1, word_r(TYPE_R, AND, 5'd5, 5'd1, 5'd2));
		step(1'b1, word_r(TYPE_R, OR, 5'd6, 5'd3, 5'd4));
		step(1'b1, word_r(TYPE_R, NOT, 5'd7, 5'd0, 5'd2));
		step(1'b1, word_i(ANDI, 5'd8, 5'd3, 16'h0FF0));
		step(1'b1, word_i(ORI, 5'd9, 5'd4, 16'hA005));
		load_reg(5'd10, rand32());
		step(1'b1, word_i(BRFL, 5'd0, 5'd10, 16'h0000));
	endtask

	task automatic test_arith();
		logic [31:0] ops_a [4];
		logic [31:0] ops_b [4];
		ops_a = '{32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h0000_0000, 32'h8000_0000};
		ops_b = '{32'h0000_0001, 32'h0000_0001, 32'h0000_0001, 32'h8000_0000};
		for (int k = 0; k < 10; k++) begin
			load_reg(5'd1, (k < 4) ? ops_a[k] : rand32());
			load_reg(5'd2, (k < 4) ? ops_b[k] : rand32());
			step(1'b1, word_r(TYPE_R, ADD, 5'd3, 5'd1, 5'd2));
			step(1'b1, word_r(TYPE_R, SUB, 5'd4, 5'd1, 5'd2));
		end
		step(1'b1, word_i(SUBI, 5'd5, 5'd0, 16'h0005)); // Wraps below zero
		step(1'b1, word_i(ADDI, 5'd6, 5'd4, 16'hFFFF));
	endtask

	task automatic test_mul_div();
		step(1'b1, word_r(TYPE_R, MUL, 5'd11, 5'd31, 5'd31));
		load_reg(5'd1, rand32());
		load_reg(5'd2, {16'h0, 16'(rand32())});
		step(1'b1, word_r(TYPE_R, MUL, 5'd3, 5'd1, 5'd2));
		step(1'b1, word_r(TYPE_R, DIV, 5'd4, 5'd1, 5'd2));
		step(1'b1, word_r(TYPE_R, DIV, 5'd5, 5'd2, 5'd1));
		step(1'b1, word_i(ADDI, 5'd6, 5'd0, 16'd100));
		step(1'b1, word_i(ADDI, 5'd7, 5'd0, 16'd7));
		step(1'b1, word_r(TYPE_R, DIV, 5'd8, 5'd6, 5'd7));
		step(1'b1, word_r(TYPE_R, DIV, 5'd9, 5'd6, 5'd0)); // Divide by zero
	endtask

	task automatic test_cmp();
		step(1'b1, word_i(ADDI, 5'd7, 5'd0, 16'd10));
		step(1'b1, word_i(ADDI, 5'd8, 5'd0, 16'd20));
		step(1'b1, word_r(CMP, 6'h00, 5'd7, 5'd8, 5'd7));
		step(1'b1, word_r(CMP, 6'h00, 5'd7, 5'd7, 5'd8));
		step(1'b1, word_r(CMP, 6'h00, 5'd8, 5'd7, 5'd7));
		step(1'b1, word_i(BRFL, 5'd0, 5'd7, 16'h0001));
		step(1'b1, word_i(BRFL, 5'd0, 5'd8, 16'h0001));
	endtask

	task automatic test_branch();
		step(1'b1, word_r(CMP, 6'h00, 5'd0, 5'd7, 5'd7));
		for (int k = 0; k < 8; k++)
			step(1'b1, word_i(BRFL, 5'd0, 5'd7, 16'(k)));
		// Idle cycles whose words would branch, write r31 and change the flag
		step(1'b0, word_i(BRFL, 5'd0, 5'd7, 16'h0000));
		step(1'b0, word_i(SUBI, 5'd31, 5'd0, 16'h0001));
		step(1'b1, word_r(TYPE_R, MUL, 5'd11, 5'd31, 5'd31));
		for (int k = 0; k < 6; k++)
			step(1'b1, word_i(BRFL, 5'd0, 5'd0, 16'(k)));
	endtask

	task automatic test_back_to_back();
		step(1'b1, word_i(ADDI, 5'd1, 5'd0, 16'h0001));
		for (int k = 0; k < 6; k++)
			step(1'b1, word_r(TYPE_R, ADD, 5'd1, 5'd1, 5'd1));
		step(1'b1, word_i(ADDI, 5'd2, 5'd1, 16'h0003));
		step(1'b1, word_r(TYPE_R, SUB, 5'd3, 5'd2, 5'd1));
		step(1'b1, word_r(TYPE_R, MUL, 5'd4, 5'd3, 5'd2));
		step(1'b1, word_i(BRFL, 5'd0, 5'd4, 16'h0000));
	endtask

	initial begin : watchdog
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		instr_valid = 1'b1; // Strobe held high through reset
		instr       = word_i(SUBI, 5'd1, 5'd0, 16'h0001);
		pend_valid  = 1'b0;
		pend_branch = 1'b0;
		shadow_flag = FLAG_NOT_ACTIVED;
		for (int r = 0; r < NUM_REGS; r++)
			shadow_regs[r] = '0;
		wait (reset === 1'b1);
		instr_valid <= 1'b0;
		test_load_logic();
		test_arith();
		test_mul_div();
		test_cmp();
		test_branch();
		test_back_to_back();
		step(1'b0, 32'h0); // Collects the last result
		total = value_errors + other_errors + dut0.chk0.fail_count;
		$display("Errors: value %0d, other %0d, assertion %0d", value_errors, other_errors,
			dut0.chk0.fail_count);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
